// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module huff_encoder_tb \
  && ./obj_dir/Vhuff_encoder_tb | tee /dev/stderr | grep -q "^all tests passed$" \
  && echo "simulation result: PASS" \
  || { echo "simulation result: FAIL"; exit 1; }

// File: tb/huff_tb_tasks.svh
// model cost of a Huffman code, the sum of all merge weights
function automatic int huffman_cost();
  int hist [NUM_SYM];
  int w [$];
  int a;
  int b;
  int cost;
  cost = 0;
  foreach (hist[s]) hist[s] = 0;
  foreach (block_chars[i]) hist[block_chars[i]]++;
  foreach (hist[s]) begin
    if (hist[s] != 0) w.push_back(hist[s]);
  end
  while (w.size() > 1) begin
    w.sort();
    a = w.pop_front();
    b = w.pop_front();
    cost += a + b;
    w.push_back(a + b);
  end
  return cost;
endfunction

// Kraft sum scaled by 2**MAX_LEN
function automatic int kraft_sum();
  int sum;
  sum = 0;
  foreach (hdr_len[s]) begin
    if (hdr_len[s] != 0) sum += 1 << (MAX_LEN - hdr_len[s]);
  end
  return sum;
endfunction

// canonical decode of the payload, codes rebuilt from the header lengths
function automatic int decode_payload();
  int                cnt [MAX_LEN+1];
  int                first [MAX_LEN+1];
  int                offs [MAX_LEN+1];
  int                order [$];
  logic [WORD_W-1:0] w;
  int                code;
  int                len;
  int                pos;
  int                n;
  int                nbits;
  foreach (cnt[l]) cnt[l] = 0;
  foreach (hdr_len[s]) begin
    if (hdr_len[s] != 0) cnt[hdr_len[s]]++;
  end
  first[0] = 0;
  offs[0]  = 0;
  // symbols sorted by length, then by symbol value
  for (int l = 1; l <= MAX_LEN; l++) begin
    first[l] = (first[l-1] + cnt[l-1]) << 1;
    offs[l]  = order.size();
    foreach (hdr_len[s]) begin
      if (hdr_len[s] == l) order.push_back(s);
    end
  end
  nbits = (words.size() > 0) ? int'(words[0].data) : 0;
  code  = 0;
  len   = 0;
  pos   = 0;
  n     = 0;
  while (pos < nbits && n < BLOCK_LEN && PAY_BASE + pos / WORD_W < words.size()) begin
    w    = words[PAY_BASE + pos / WORD_W].data;
    code = (code << 1) | int'(w[WORD_W - 1 - pos % WORD_W]);
    len++;
    pos++;
    if (len > MAX_LEN) return n;
    if (code >= first[len] && code - first[len] < cnt[len]) begin
      decoded[n] = order[offs[len] + code - first[len]];
      n++;
      code = 0;
      len  = 0;
    end
  end
  return n;
endfunction

// File: tb/huff_encoder_tb.sv
`timescale 1ns/10ps
module huff_encoder_tb import huff_pkg::*; ();

  localparam int BLOCKS         = 6;
  localparam int TIMEOUT_CYCLES = BLOCKS * 20000;
  localparam int PAY_BASE       = 1 + HDR_WORDS;
  localparam int PER_WORD       = WORD_W / LEN_W;
  localparam int SINGLE_CHAR    = 'h41;

  // test ids
  localparam int T_SINGLE = 0;
  localparam int T_COST   = 1;
  localparam int T_HDR    = 2;
  localparam int T_TRIP   = 3;
  localparam int T_BP     = 4;
  localparam int T_BUSY   = 5;

  logic             hwclk = 1'b0;
  logic             reset;
  logic             read_in_pulse;
  logic [SYM_W-1:0] char_in;
  logic             esp_ack = 1'b0;
  logic             busy;
  stream_word_t     out_word;
  logic             out_valid;

  int               seed = 60;
  bit               ack_random = 1'b0;
  int               cycle_count = 0;
  int               test_err [6];
  int               tests_done = 0;
  int               tests_bad = 0;
  logic [SYM_W-1:0] block_chars [BLOCK_LEN];
  int               hdr_len [NUM_SYM];
  int               decoded [BLOCK_LEN];
  stream_word_t     words [$];
  stream_word_t     ref_words [$];
  stream_word_t     held_word;
  bit               held_valid = 1'b0;
  bit               last_xfer = 1'b0;
  bit               fall_due = 1'b0;

  `include "huff_tb_tasks.svh"

  huff_encoder_top dut0 (
    .hwclk           (hwclk),
    .reset           (reset),
    .read_in_pulse_i (read_in_pulse),
    .char_i          (char_in),
    .esp_ack_i       (esp_ack),
    .busy_o          (busy),
    .out_word_o      (out_word),
    .out_valid_o     (out_valid)
  );

  always #4 hwclk = ~hwclk;

  // about 30 percent acknowledge when randomized
  always @(posedge hwclk) begin
    esp_ack <= ack_random ? ({$random(seed)} % 100 < 30) : 1'b1;
  end

  task automatic check(input int test_id, input bit ok, input string msg);
    assert (ok) else begin
      $display("ERR %0t: %s", $time, msg);
      test_err[test_id]++;
    end
  endtask

  // words collected and held words watched between edges
  always @(negedge hwclk) begin
    if (!reset) begin
      if (held_valid) begin
        check(T_BP, out_valid && (out_word == held_word),
              "output word changed before acknowledge");
      end
      // busy drops one cycle after the last word is taken
      if (fall_due) begin
        check(T_BUSY, !busy, "busy still high two cycles after the last word");
      end
      fall_due = 1'b0;
      if (last_xfer) begin
        check(T_BUSY, busy, "busy fell in the cycle of the last word transfer");
        fall_due = 1'b1;
      end
      last_xfer = out_valid && esp_ack && out_word.last;
      if (out_valid && esp_ack) words.push_back(out_word);
      held_valid = out_valid && !esp_ack;
      held_word  = out_word;
    end
  end

  task automatic report_test(input int test_id, input string name);
    tests_done++;
    if (test_err[test_id] == 0) begin
      $display("test %s: pass", name);
    end else begin
      tests_bad++;
      $display("test %s: FAIL with %0d errors", name, test_err[test_id]);
    end
  endtask

  task automatic fill_single(input logic [SYM_W-1:0] sym);
    foreach (block_chars[i]) block_chars[i] = sym;
  endtask

  task automatic fill_random(input int alpha, input bit skew);
    int a;
    int b;
    foreach (block_chars[i]) begin
      a = {$random(seed)} % alpha;
      b = {$random(seed)} % alpha;
      // the smaller of two draws favors low characters
      block_chars[i] = SYM_W'((skew && b < a) ? b : a);
    end
  endtask

  task automatic send_block();
    for (int i = 0; i < BLOCK_LEN; i++) begin
      @(posedge hwclk);
      read_in_pulse <= 1'b1;
      char_in       <= block_chars[i];
    end
    @(posedge hwclk);
    read_in_pulse <= 1'b0;
  endtask

  // junk characters while the block is processed
  task automatic pulse_while_busy(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge hwclk);
      read_in_pulse <= 1'b1;
      char_in       <= SYM_W'(i * 37 + 5);
    end
    @(posedge hwclk);
    read_in_pulse <= 1'b0;
  endtask

  task automatic wait_idle();
    @(negedge hwclk);
    while (busy) @(negedge hwclk);
  endtask

  task automatic run_block();
    words.delete();
    send_block();
    wait_idle();
  endtask

  task automatic read_header();
    logic [WORD_W-1:0] w;
    foreach (hdr_len[s]) begin
      if (words.size() >= PAY_BASE) begin
        w          = words[1 + s / PER_WORD].data;
        hdr_len[s] = int'(w[WORD_W - 1 - (s % PER_WORD) * LEN_W -: LEN_W]);
      end else begin
        hdr_len[s] = 0;
      end
    end
  endtask

  task automatic validate_framing(input int test_id);
    int pay_words;
    check(test_id, words.size() > 0, "no output words were received");
    pay_words = (int'(words[0].data) + WORD_W - 1) / WORD_W;
    check(test_id, words.size() == PAY_BASE + pay_words,
          $sformatf("got %0d words, expected %0d", words.size(), PAY_BASE + pay_words));
    foreach (words[i]) begin
      check(test_id, words[i].last == (i == words.size() - 1),
            $sformatf("last flag wrong on word %0d", i));
    end
  endtask

  task automatic audit_header(input int test_id);
    int hist [NUM_SYM];
    foreach (hist[s]) hist[s] = 0;
    foreach (block_chars[i]) hist[block_chars[i]]++;
    foreach (hdr_len[s]) begin
      if (hist[s] == 0) begin
        check(test_id, hdr_len[s] == 0,
              $sformatf("absent symbol %0d has length %0d", s, hdr_len[s]));
      end else begin
        check(test_id, hdr_len[s] >= 1 && hdr_len[s] <= MAX_LEN,
              $sformatf("symbol %0d has length %0d", s, hdr_len[s]));
      end
    end
    check(test_id, kraft_sum() == (1 << MAX_LEN),
          $sformatf("Kraft sum %0d, expected %0d", kraft_sum(), 1 << MAX_LEN));
  endtask

  task automatic compare_round_trip(input int test_id);
    int n;
    n = decode_payload();
    check(test_id, n == BLOCK_LEN, $sformatf("decoded %0d characters, expected %0d", n, BLOCK_LEN));
    for (int i = 0; i < n; i++) begin
      check(test_id, decoded[i] == int'(block_chars[i]),
            $sformatf("character %0d decoded as %0d, expected %0d", i, decoded[i],
                      block_chars[i]));
    end
  endtask

  initial begin
    reset         = 1'b1;
    read_in_pulse = 1'b0;
    char_in       = '0;
    foreach (test_err[t]) test_err[t] = 0;
    repeat (8) @(posedge hwclk);
    reset <= 1'b0;

    // one character repeated over the block
    fill_single(SYM_W'(SINGLE_CHAR));
    run_block();
    read_header();
    validate_framing(T_SINGLE);
    check(T_SINGLE, int'(words[0].data) == BLOCK_LEN,
          $sformatf("count word %0d, expected %0d", words[0].data, BLOCK_LEN));
    foreach (hdr_len[s]) begin
      check(T_SINGLE, hdr_len[s] == ((s == SINGLE_CHAR) ? 1 : 0),
            $sformatf("symbol %0d has length %0d", s, hdr_len[s]));
    end
    for (int i = PAY_BASE; i < words.size(); i++) begin
      check(T_SINGLE, words[i].data == '0, $sformatf("payload word %0d not zero", i));
    end
    compare_round_trip(T_SINGLE);
    report_test(T_SINGLE, "single_symbol");

    // full alphabet, then a skewed small one
    for (int b = 0; b < 2; b++) begin
      fill_random((b == 0) ? NUM_SYM : 12, b == 1);
      run_block();
      read_header();
      check(T_COST, int'(words[0].data) == huffman_cost(),
            $sformatf("count word %0d, expected %0d", words[0].data, huffman_cost()));
      audit_header(T_HDR);
      validate_framing(T_TRIP);
      compare_round_trip(T_TRIP);
    end
    report_test(T_COST, "optimal_cost");
    report_test(T_HDR, "header_validity");
    report_test(T_TRIP, "round_trip");

    // same block with ack held high, then random ack
    fill_random(40, 1'b1);
    run_block();
    ref_words = words;
    ack_random = 1'b1;
    words.delete();
    send_block();
    pulse_while_busy(100);
    wait_idle();
    ack_random = 1'b0;
    check(T_BP, words.size() == ref_words.size(),
          $sformatf("got %0d words, expected %0d", words.size(), ref_words.size()));
    foreach (ref_words[i]) begin
      if (i < words.size()) begin
        check(T_BP, words[i] == ref_words[i], $sformatf("word %0d differs under back-pressure", i));
      end
    end
    report_test(T_BP, "back_pressure");

    // block right after the ignored pulses
    fill_random(NUM_SYM, 1'b0);
    run_block();
    read_header();
    compare_round_trip(T_BUSY);
    report_test(T_BUSY, "busy_ignore");

    $display("summary: %0d run, %0d ok, %0d bad", tests_done, tests_done - tests_bad, tests_bad);
    if (tests_bad == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge hwclk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("tests failed");
    $finish;
  end

endmodule

// File: verilog/huff_bit_packer.sv
`timescale 1ns/10ps
module huff_bit_packer import huff_pkg::*; (
  input  logic                     hwclk,
  input  logic                     reset,
  input  huff_phase_t              phase_i,
  input  logic [NUM_SYM*LEN_W-1:0] len_i,
  input  code_entry_t              entry_i,
  output logic [SYM_W-1:0]         lookup_sym_o,
  output logic [ADDR_W-1:0]        rd_addr_o,
  input  logic [SYM_W-1:0]         rd_sym_i,
  output stream_word_t             out_word_o,
  output logic                     out_valid_o,
  input  logic                     esp_ack_i,
  output logic                     done_o
);

  typedef enum logic [2:0] {
    P_IDLE,
    P_SUM,
    P_COUNT,
    P_HDR,
    P_PAY,
    P_DRAIN
  } pack_state_t;

  pack_state_t                   state_q, state_n;
  logic [ADDR_W-1:0]             ptr_q, ptr_n;
  logic [BITS_W-1:0]             bits_q, bits_n;
  logic [$clog2(HDR_WORDS)-1:0]  hdr_q, hdr_n;
  logic [ACC_W-1:0]              acc_q, acc_n;
  logic [SYM_W-1:0]              fill_q, fill_n;
  logic                          walk_done_q, walk_done_n;
  logic                          slot_free;
  logic                          load;
  stream_word_t                  word_n;
  logic [ACC_W-1:0]              code_ext;
  logic [WORD_W-1:0]             hdr_word;
  logic [LEN_W-1:0]              sym_len;

  assign rd_addr_o    = ptr_q;
  assign lookup_sym_o = rd_sym_i;
  assign sym_len      = len_i[rd_sym_i*LEN_W +: LEN_W];
  // output slot empties on the same edge it is refilled
  assign slot_free    = !out_valid_o || esp_ack_i;
  // code moved to just below the bits already held
  assign code_ext = (ACC_W'(entry_i.code) << (ACC_W - int'(entry_i.len))) >> fill_q;

  // eight lengths per header word, lowest symbol in the top nibble
  always_comb begin
    for (int k = 0; k < WORD_W / LEN_W; k++) begin
      hdr_word[WORD_W-1-k*LEN_W -: LEN_W] =
        len_i[(int'(hdr_q) * (WORD_W / LEN_W) + k) * LEN_W +: LEN_W];
    end
  end

  always_comb begin
    state_n     = state_q;
    ptr_n       = ptr_q;
    bits_n      = bits_q;
    hdr_n       = hdr_q;
    acc_n       = acc_q;
    fill_n      = fill_q;
    walk_done_n = walk_done_q;
    load        = 1'b0;
    word_n      = '0;
    case (state_q)
      P_IDLE: begin
        if (phase_i == PH_EMIT) begin
          ptr_n   = '0;
          bits_n  = '0;
          state_n = P_SUM;
        end
      end
      P_SUM: begin
        // payload size from one pass over the block
        bits_n = bits_q + BITS_W'(sym_len);
        ptr_n  = ptr_q + 1'b1;
        if (ptr_q == ADDR_W'(BLOCK_LEN - 1)) state_n = P_COUNT;
      end
      P_COUNT: begin
        if (slot_free) begin
          load        = 1'b1;
          word_n.data = WORD_W'(bits_q);
          hdr_n       = '0;
          state_n     = P_HDR;
        end
      end
      P_HDR: begin
        if (slot_free) begin
          load        = 1'b1;
          word_n.data = hdr_word;
          hdr_n       = hdr_q + 1'b1;
          if (hdr_q == $bits(hdr_q)'(HDR_WORDS - 1)) begin
            acc_n       = '0;
            fill_n      = '0;
            walk_done_n = 1'b0;
            state_n     = P_PAY;
          end
        end
      end
      P_PAY: begin
        if (fill_q >= SYM_W'(WORD_W)) begin
          // full word ready, walk waits for the slot
          if (slot_free) begin
            load        = 1'b1;
            word_n.data = acc_q[ACC_W-1 -: WORD_W];
            word_n.last = walk_done_q && (fill_q == SYM_W'(WORD_W));
            acc_n       = acc_q << WORD_W;
            fill_n      = fill_q - SYM_W'(WORD_W);
            if (word_n.last) state_n = P_DRAIN;
          end
        end else if (!walk_done_q) begin
          acc_n  = acc_q | code_ext;
          fill_n = fill_q + SYM_W'(entry_i.len);
          ptr_n  = ptr_q + 1'b1;
          if (ptr_q == ADDR_W'(BLOCK_LEN - 1)) walk_done_n = 1'b1;
        end else if (slot_free) begin
          // partial tail, low bits already zero
          load        = 1'b1;
          word_n.data = acc_q[ACC_W-1 -: WORD_W];
          word_n.last = 1'b1;
          fill_n      = '0;
          state_n     = P_DRAIN;
        end
      end
      P_DRAIN: begin
        if (phase_i != PH_EMIT) state_n = P_IDLE;
      end
      default: state_n = P_IDLE;
    endcase
  end

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      state_q     <= P_IDLE;
      ptr_q       <= '0;
      hdr_q       <= '0;
      fill_q      <= '0;
      walk_done_q <= 1'b0;
      out_valid_o <= 1'b0;
      done_o      <= 1'b0;
    end else begin
      state_q     <= state_n;
      ptr_q       <= ptr_n;
      hdr_q       <= hdr_n;
      fill_q      <= fill_n;
      walk_done_q <= walk_done_n;
      done_o      <= out_valid_o && esp_ack_i && out_word_o.last;
      if (load) begin
        out_valid_o <= 1'b1;
      end else if (esp_ack_i) begin
        out_valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge hwclk) begin
    bits_q <= bits_n;
    acc_q  <= acc_n;
    if (load) out_word_o <= word_n;
  end

endmodule

// File: verilog/huff_block_control.sv
`timescale 1ns/10ps
module huff_block_control import huff_pkg::*; (
  input  logic        hwclk,
  input  logic        reset,
  input  logic        block_full_i,
  input  logic        lengths_done_i,
  input  logic        codes_done_i,
  input  logic        emit_done_i,
  output huff_phase_t phase_o,
  output logic        busy_o
);

  huff_phase_t phase_q, phase_n;

  assign phase_o = phase_q;

  // each stage hands over on its done pulse
  always_comb begin
    phase_n = phase_q;
    case (phase_q)
      PH_COLLECT: if (block_full_i) phase_n = PH_BUILD;
      PH_BUILD:   if (lengths_done_i) phase_n = PH_ASSIGN;
      PH_ASSIGN:  if (codes_done_i) phase_n = PH_EMIT;
      PH_EMIT:    if (emit_done_i) phase_n = PH_COLLECT;
      default:    phase_n = PH_COLLECT;
    endcase
  end

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      phase_q <= PH_COLLECT;
      busy_o  <= 1'b0;
    end else begin
      phase_q <= phase_n;
      // busy follows the phase on the same edge
      busy_o  <= (phase_n != PH_COLLECT);
    end
  end

endmodule

// File: verilog/huff_canonical_codes.sv
`timescale 1ns/10ps
module huff_canonical_codes import huff_pkg::*; (
  input  logic                     hwclk,
  input  logic                     reset,
  input  huff_phase_t              phase_i,
  input  logic [NUM_SYM*LEN_W-1:0] len_i,
  input  logic [SYM_W-1:0]         lookup_sym_i,
  output code_entry_t              entry_o,
  output logic                     done_o
);

  typedef enum logic [1:0] {
    C_IDLE,
    C_FIRST,
    C_WALK,
    C_HOLD
  } cb_state_t;

  cb_state_t          state_q;
  logic [SYM_W:0]     cnt_n [MAX_LEN+1];
  logic [SYM_W:0]     cnt_q [MAX_LEN+1];
  logic [MAX_LEN-1:0] next_code_q [MAX_LEN+1];
  code_entry_t        table_q [NUM_SYM];
  logic [LEN_W-1:0]   lvl_q;
  logic [SYM_W-1:0]   sym_q;
  logic [LEN_W-1:0]   cur_len;
  logic               start;

  assign start   = (state_q == C_IDLE) && (phase_i == PH_ASSIGN);
  assign cur_len = len_i[sym_q*LEN_W +: LEN_W];
  assign entry_o = table_q[lookup_sym_i];

  // symbols per code length, absent symbols excluded
  always_comb begin
    for (int l = 0; l <= MAX_LEN; l++) begin
      cnt_n[l] = '0;
    end
    for (int s = 0; s < NUM_SYM; s++) begin
      cnt_n[len_i[s*LEN_W +: LEN_W]] += 1'b1;
    end
    cnt_n[0] = '0;
  end

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      state_q <= C_IDLE;
      lvl_q   <= '0;
      sym_q   <= '0;
      done_o  <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state_q)
        C_IDLE: begin
          if (start) begin
            lvl_q   <= LEN_W'(1);
            state_q <= C_FIRST;
          end
        end
        C_FIRST: begin
          lvl_q <= lvl_q + 1'b1;
          if (lvl_q == LEN_W'(MAX_LEN)) begin
            sym_q   <= '0;
            state_q <= C_WALK;
          end
        end
        C_WALK: begin
          sym_q <= sym_q + 1'b1;
          if (sym_q == SYM_W'(NUM_SYM - 1)) begin
            done_o  <= 1'b1;
            state_q <= C_HOLD;
          end
        end
        C_HOLD: begin
          if (phase_i != PH_ASSIGN) state_q <= C_IDLE;
        end
        default: state_q <= C_IDLE;
      endcase
    end
  end

  always_ff @(posedge hwclk) begin
    if (start) begin
      cnt_q          <= cnt_n;
      next_code_q[0] <= '0;
    end
    // one code length per cycle
    if (state_q == C_FIRST) begin
      next_code_q[lvl_q] <= (next_code_q[lvl_q - 1'b1] + MAX_LEN'(cnt_q[lvl_q - 1'b1])) << 1;
    end
    if (state_q == C_WALK) begin
      table_q[sym_q].len  <= cur_len;
      table_q[sym_q].code <= (cur_len != '0) ? next_code_q[cur_len] : '0;
      if (cur_len != '0) begin
        next_code_q[cur_len] <= next_code_q[cur_len] + 1'b1;
      end
    end
  end

endmodule

// File: verilog/huff_code_lengths.sv
`timescale 1ns/10ps
module huff_code_lengths import huff_pkg::*; (
  input  logic                     hwclk,
  input  logic                     reset,
  input  huff_phase_t              phase_i,
  input  logic [NUM_SYM*CNT_W-1:0] hist_i,
  output logic [NUM_SYM*LEN_W-1:0] len_o,
  output logic                     done_o
);

  typedef enum logic [1:0] {
    L_IDLE,
    L_SCAN,
    L_MERGE,
    L_HOLD
  } len_state_t;

  len_state_t        state_q;
  logic [CNT_W-1:0]  weight_q [NUM_SYM];
  logic [SYM_W-1:0]  group_q [NUM_SYM];
  logic [LEN_W-1:0]  len_q [NUM_SYM];
  logic [NUM_SYM-1:0] active_q;
  logic [SYM_W-1:0]  scan_q;
  logic [SYM_W-1:0]  min1_q, min2_q;
  logic              min1_v_q, min2_v_q;
  logic              merged_q;
  logic              load;
  logic              merge;

  assign load  = (state_q == L_IDLE) && (phase_i == PH_BUILD);
  // a second candidate means there is still something to merge
  assign merge = (state_q == L_MERGE) && min2_v_q;

  always_comb begin
    for (int s = 0; s < NUM_SYM; s++) begin
      len_o[s*LEN_W +: LEN_W] = len_q[s];
    end
  end

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      state_q  <= L_IDLE;
      active_q <= '0;
      scan_q   <= '0;
      min1_q   <= '0;
      min2_q   <= '0;
      min1_v_q <= 1'b0;
      min2_v_q <= 1'b0;
      merged_q <= 1'b0;
      done_o   <= 1'b0;
      for (int s = 0; s < NUM_SYM; s++) begin
        len_q[s] <= '0;
      end
    end else begin
      done_o <= 1'b0;
      case (state_q)
        L_IDLE: begin
          if (load) begin
            // one leaf node per symbol that occurs
            for (int s = 0; s < NUM_SYM; s++) begin
              active_q[s] <= (hist_i[s*CNT_W +: CNT_W] != '0);
              len_q[s]    <= '0;
            end
            scan_q   <= '0;
            min1_v_q <= 1'b0;
            min2_v_q <= 1'b0;
            merged_q <= 1'b0;
            state_q  <= L_SCAN;
          end
        end
        L_SCAN: begin
          // strict compare keeps the lower index on ties
          if (active_q[scan_q]) begin
            if (!min1_v_q || (weight_q[scan_q] < weight_q[min1_q])) begin
              min2_q   <= min1_q;
              min2_v_q <= min1_v_q;
              min1_q   <= scan_q;
              min1_v_q <= 1'b1;
            end else if (!min2_v_q || (weight_q[scan_q] < weight_q[min2_q])) begin
              min2_q   <= scan_q;
              min2_v_q <= 1'b1;
            end
          end
          scan_q <= scan_q + 1'b1;
          if (scan_q == SYM_W'(NUM_SYM - 1)) begin
            state_q <= L_MERGE;
          end
        end
        L_MERGE: begin
          if (min2_v_q) begin
            active_q[min2_q] <= 1'b0;
            for (int s = 0; s < NUM_SYM; s++) begin
              if ((group_q[s] == min1_q) || (group_q[s] == min2_q)) begin
                len_q[s] <= len_q[s] + 1'b1;
              end
            end
            merged_q <= 1'b1;
            min1_v_q <= 1'b0;
            min2_v_q <= 1'b0;
            state_q  <= L_SCAN;
          end else begin
            // lone symbol still needs one bit
            if (!merged_q) begin
              len_q[min1_q] <= LEN_W'(1);
            end
            done_o  <= 1'b1;
            state_q <= L_HOLD;
          end
        end
        L_HOLD: begin
          if (phase_i != PH_BUILD) state_q <= L_IDLE;
        end
        default: state_q <= L_IDLE;
      endcase
    end
  end

  // node weights and group ids
  always_ff @(posedge hwclk) begin
    if (load) begin
      for (int s = 0; s < NUM_SYM; s++) begin
        weight_q[s] <= hist_i[s*CNT_W +: CNT_W];
        group_q[s]  <= SYM_W'(s);
      end
    end else if (merge) begin
      weight_q[min1_q] <= weight_q[min1_q] + weight_q[min2_q];
      for (int s = 0; s < NUM_SYM; s++) begin
        if (group_q[s] == min2_q) group_q[s] <= min1_q;
      end
    end
  end

endmodule

// File: verilog/huff_encoder_top.sv
`timescale 1ns/10ps
module huff_encoder_top import huff_pkg::*; (
  input  logic             hwclk,
  input  logic             reset,
  input  logic             read_in_pulse_i,
  input  logic [SYM_W-1:0] char_i,
  input  logic             esp_ack_i,
  output logic             busy_o,
  output stream_word_t     out_word_o,
  output logic             out_valid_o
);

  huff_phase_t              phase;
  logic                     block_full;
  logic                     lengths_done;
  logic                     codes_done;
  logic                     emit_done;
  logic [NUM_SYM*CNT_W-1:0] hist_count;
  logic [NUM_SYM*LEN_W-1:0] code_len;
  logic [ADDR_W-1:0]        rd_addr;
  logic [SYM_W-1:0]         rd_sym;
  logic [SYM_W-1:0]         lookup_sym;
  code_entry_t              code_entry;

  huff_block_control controller (
    .hwclk          (hwclk),
    .reset          (reset),
    .block_full_i   (block_full),
    .lengths_done_i (lengths_done),
    .codes_done_i   (codes_done),
    .emit_done_i    (emit_done),
    .phase_o        (phase),
    .busy_o         (busy_o)
  );

  huff_symbol_buffer sym_buffer (
    .hwclk           (hwclk),
    .reset           (reset),
    .phase_i         (phase),
    .read_in_pulse_i (read_in_pulse_i),
    .char_i          (char_i),
    .rd_addr_i       (rd_addr),
    .rd_sym_o        (rd_sym),
    .hist_o          (hist_count),
    .block_full_o    (block_full)
  );

  huff_code_lengths len_engine (
    .hwclk   (hwclk),
    .reset   (reset),
    .phase_i (phase),
    .hist_i  (hist_count),
    .len_o   (code_len),
    .done_o  (lengths_done)
  );

  huff_canonical_codes codebook (
    .hwclk        (hwclk),
    .reset        (reset),
    .phase_i      (phase),
    .len_i        (code_len),
    .lookup_sym_i (lookup_sym),
    .entry_o      (code_entry),
    .done_o       (codes_done)
  );

  huff_bit_packer packer (
    .hwclk        (hwclk),
    .reset        (reset),
    .phase_i      (phase),
    .len_i        (code_len),
    .entry_i      (code_entry),
    .lookup_sym_o (lookup_sym),
    .rd_addr_o    (rd_addr),
    .rd_sym_i     (rd_sym),
    .out_word_o   (out_word_o),
    .out_valid_o  (out_valid_o),
    .esp_ack_i    (esp_ack_i),
    .done_o       (emit_done)
  );

endmodule

// File: verilog/huff_pkg.sv
package huff_pkg;

  // alphabet and block sizes
  localparam int SYM_W     = 7;
  localparam int NUM_SYM   = 128;
  localparam int BLOCK_LEN = 64;
  localparam int ADDR_W    = 6;

  // histogram counts, 64 fits in seven bits
  localparam int CNT_W     = 7;

  // code lengths
  localparam int LEN_W     = 4;
  localparam int MAX_LEN   = 15;

  // output stream
  localparam int WORD_W    = 32;
  localparam int HDR_WORDS = 16;
  localparam int BITS_W    = 10;
  localparam int ACC_W     = 2 * WORD_W;

  typedef enum logic [1:0] {
    PH_COLLECT,
    PH_BUILD,
    PH_ASSIGN,
    PH_EMIT
  } huff_phase_t;

  // code is right aligned, len bits of it are valid
  typedef struct packed {
    logic [MAX_LEN-1:0] code;
    logic [LEN_W-1:0]   len;
  } code_entry_t;

  typedef struct packed {
    logic [WORD_W-1:0] data;
    logic              last;
  } stream_word_t;

endpackage

// File: verilog/huff_symbol_buffer.sv
`timescale 1ns/10ps
module huff_symbol_buffer import huff_pkg::*; (
  input  logic                       hwclk,
  input  logic                       reset,
  input  huff_phase_t                phase_i,
  input  logic                       read_in_pulse_i,
  input  logic [SYM_W-1:0]           char_i,
  input  logic [ADDR_W-1:0]          rd_addr_i,
  output logic [SYM_W-1:0]           rd_sym_o,
  output logic [NUM_SYM*CNT_W-1:0]   hist_o,
  output logic                       block_full_o
);

  logic [SYM_W-1:0]  store_q [BLOCK_LEN];
  logic [CNT_W-1:0]  hist_q [NUM_SYM];
  logic [ADDR_W-1:0] wr_ptr_q;
  logic [ADDR_W-1:0] wr_addr;
  huff_phase_t       phase_prev_q;
  logic              accept;
  logic              restart;

  // busy is low exactly while collecting
  assign accept  = read_in_pulse_i && (phase_i == PH_COLLECT);
  // first collect cycle after a finished block
  assign restart = (phase_i == PH_COLLECT) && (phase_prev_q != PH_COLLECT);
  assign wr_addr = restart ? '0 : wr_ptr_q;

  assign block_full_o = accept && (wr_addr == ADDR_W'(BLOCK_LEN - 1));
  assign rd_sym_o     = store_q[rd_addr_i];

  always_comb begin
    for (int s = 0; s < NUM_SYM; s++) begin
      hist_o[s*CNT_W +: CNT_W] = hist_q[s];
    end
  end

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      phase_prev_q <= PH_COLLECT;
      wr_ptr_q     <= '0;
      for (int s = 0; s < NUM_SYM; s++) begin
        hist_q[s] <= '0;
      end
    end else begin
      phase_prev_q <= phase_i;
      if (restart) begin
        wr_ptr_q <= '0;
        for (int s = 0; s < NUM_SYM; s++) begin
          hist_q[s] <= '0;
        end
      end
      // a character on the restart cycle lands in a cleared bin
      if (accept) begin
        wr_ptr_q <= wr_addr + 1'b1;
        if (restart) begin
          hist_q[char_i] <= CNT_W'(1);
        end else begin
          hist_q[char_i] <= hist_q[char_i] + 1'b1;
        end
      end
    end
  end

  // block store, kept through emit for the packer
  always_ff @(posedge hwclk) begin
    if (accept) begin
      store_q[wr_addr] <= char_i;
    end
  end

endmodule

// File: vlog.f
+incdir+tb
verilog/huff_pkg.sv
verilog/huff_block_control.sv
verilog/huff_symbol_buffer.sv
verilog/huff_code_lengths.sv
verilog/huff_canonical_codes.sv
verilog/huff_bit_packer.sv
verilog/huff_encoder_top.sv
tb/huff_encoder_tb.sv
